// File: verilog/muldiv_pkg.sv
/* Widths and operation encoding shared by the multiply/divide unit.
   Imported by each RTL module and by the testbench checker. */
package muldiv_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int XLEN  = 32;   // Data path
  localparam int TAG_W = 6;    // Rename tag

  // --------------------
  // Operations
  // --------------------
  typedef enum logic [3:0] {
    OP_NONE   = 4'h0,   // Empty stage
    OP_MUL    = 4'h1,
    OP_MULH   = 4'h2,
    OP_MULHSU = 4'h3,
    OP_MULHU  = 4'h4,
    OP_DIV    = 4'h8,
    OP_DIVU   = 4'h9,
    OP_REM    = 4'ha,
    OP_REMU   = 4'hb
  } muldiv_op_t;

endpackage

// File: verilog/mul_pipe.sv
/* Multiplier pipeline folding MUL_UNROLL bits of rs2 per stage.
   Takes a new operation every cycle, result leaves MUL_STEP cycles later. */
module mul_pipe
  import muldiv_pkg::*;
#(
  parameter int MUL_UNROLL = 8
) (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_start,
  input  muldiv_op_t       i_op,
  input  logic [TAG_W-1:0] i_tag,
  input  logic [XLEN-1:0]  i_rs1,
  input  logic [XLEN-1:0]  i_rs2,
  input  logic             i_flush,
  output logic             o_valid,
  output logic [TAG_W-1:0] o_tag,
  output logic [XLEN-1:0]  o_res
);

  localparam int MUL_STEP = (XLEN + MUL_UNROLL - 1) / MUL_UNROLL;
  localparam int PW       = 2 * XLEN + 1;           // Running product
  localparam int PPW      = XLEN + MUL_UNROLL + 2;  // Partial product

  logic [XLEN:0]    w_op1;
  logic [XLEN:0]    w_op2;
  logic [PW-1:0]    w_prod  [0:MUL_STEP-1];

  logic             r_valid [1:MUL_STEP];
  muldiv_op_t       r_op    [1:MUL_STEP];
  logic [TAG_W-1:0] r_tag   [1:MUL_STEP];
  logic [PW-1:0]    r_prod  [1:MUL_STEP];
  logic [XLEN:0]    r_op1   [1:MUL_STEP-1];
  logic [XLEN:0]    r_op2   [1:MUL_STEP-1];

  // rs1 is signed except for MULHU, rs2 only for MUL and MULH
  assign w_op1 = (i_op == OP_MULHU) ? {1'b0, i_rs1} : {i_rs1[XLEN-1], i_rs1};
  assign w_op2 = (i_op == OP_MUL || i_op == OP_MULH) ? {i_rs2[XLEN-1], i_rs2} : {1'b0, i_rs2};

  // --------------------
  // Stage arithmetic
  // --------------------
  for (genvar s = 0; s < MUL_STEP; s++) begin : g_stage
    logic [XLEN:0]         op1;
    logic [XLEN:0]         op2;
    logic [MUL_UNROLL:0]   step;
    logic signed [PPW-1:0] a_x;
    logic signed [PPW-1:0] b_x;
    logic signed [PPW-1:0] pp;

    if (s == 0) begin : g_src
      assign op1 = w_op1;
      assign op2 = w_op2;
    end else begin : g_src
      assign op1 = r_op1[s];
      assign op2 = r_op2[s];
    end

    // Sign bit of rs2 weighs negative in the last slice
    assign step = {(s == MUL_STEP - 1) && op2[XLEN], op2[MUL_UNROLL*s +: MUL_UNROLL]};
    assign a_x  = {{(MUL_UNROLL + 1){op1[XLEN]}}, op1};
    assign b_x  = {{(XLEN + 1){step[MUL_UNROLL]}}, step};
    assign pp   = a_x * b_x;

    if (s == 0) begin : g_sum
      assign w_prod[s] = PW'(pp);
    end else begin : g_sum
      localparam int HW = PW - MUL_UNROLL * s;
      logic [HW-1:0] hi;

      assign hi        = r_prod[s][PW-1:MUL_UNROLL*s] + HW'(pp);   // Low bits already final
      assign w_prod[s] = {hi, r_prod[s][MUL_UNROLL*s-1:0]};
    end
  end

  // --------------------
  // Pipeline registers
  // --------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int s = 1; s <= MUL_STEP; s++) begin
        r_valid[s] <= 1'b0;
        r_op[s]    <= OP_NONE;
      end
    end else begin
      r_valid[1] <= i_start & ~i_flush;
      r_op[1]    <= i_op;
      for (int s = 2; s <= MUL_STEP; s++) begin
        r_valid[s] <= r_valid[s-1] & ~i_flush;   // Flush kills all stages
        r_op[s]    <= r_op[s-1];
      end
    end
  end

  always_ff @(posedge i_clk) begin
    r_tag[1] <= i_tag;
    r_op1[1] <= w_op1;
    r_op2[1] <= w_op2;
    for (int s = 1; s <= MUL_STEP; s++) begin
      r_prod[s] <= w_prod[s-1];
    end
    for (int s = 2; s <= MUL_STEP; s++) begin
      r_tag[s] <= r_tag[s-1];
    end
    for (int s = 2; s < MUL_STEP; s++) begin
      r_op1[s] <= r_op1[s-1];
      r_op2[s] <= r_op2[s-1];
    end
  end

  assign o_valid = r_valid[MUL_STEP];
  assign o_tag   = r_tag[MUL_STEP];
  assign o_res   = (r_op[MUL_STEP] inside {OP_MULH, OP_MULHSU, OP_MULHU}) ?
                   r_prod[MUL_STEP][2*XLEN-1:XLEN] :    // High word
                   r_prod[MUL_STEP][XLEN-1:0];

endmodule

// File: verilog/div_unit.sv
/* Radix-2 restoring divider for DIV, DIVU, REM and REMU, one operation at a time.
   The finished result waits in S_DONE until the shared output is free. */
module div_unit
  import muldiv_pkg::*;
(
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_start,
  input  muldiv_op_t       i_op,
  input  logic [TAG_W-1:0] i_tag,
  input  logic [XLEN-1:0]  i_rs1,
  input  logic [XLEN-1:0]  i_rs2,
  input  logic             i_flush,
  input  logic             i_resp_ready,
  output logic             o_idle,
  output logic             o_valid,
  output logic [TAG_W-1:0] o_tag,
  output logic [XLEN-1:0]  o_res
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_CALC,
    S_FIX,
    S_DONE
  } div_state_t;

  localparam int              CNT_W    = $clog2(XLEN);
  localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN - 1){1'b0}}};

  div_state_t       r_state;
  logic [CNT_W-1:0] r_cnt;
  logic [XLEN-1:0]  r_quo;      // Dividend out, quotient in
  logic [XLEN-1:0]  r_rem;
  logic [XLEN-1:0]  r_dvs;
  logic             r_is_rem;
  logic             r_q_neg;
  logic             r_r_neg;
  logic [TAG_W-1:0] r_tag;
  logic [XLEN-1:0]  r_res;

  logic             w_signed;
  logic             w_is_rem;
  logic             w_div_zero;
  logic             w_ovf;
  logic [XLEN-1:0]  w_abs1;
  logic [XLEN-1:0]  w_abs2;
  logic [XLEN:0]    w_shift;
  logic [XLEN+1:0]  w_diff;

  assign w_signed   = (i_op == OP_DIV) || (i_op == OP_REM);
  assign w_is_rem   = (i_op == OP_REM) || (i_op == OP_REMU);
  assign w_abs1     = (w_signed && i_rs1[XLEN-1]) ? -i_rs1 : i_rs1;
  assign w_abs2     = (w_signed && i_rs2[XLEN-1]) ? -i_rs2 : i_rs2;
  assign w_div_zero = (i_rs2 == '0);
  assign w_ovf      = w_signed && (i_rs1 == MOST_NEG) && (i_rs2 == '1);

  // One restoring step
  assign w_shift = {r_rem, r_quo[XLEN-1]};
  assign w_diff  = {1'b0, w_shift} - {2'b00, r_dvs};

  // --------------------
  // FSM
  // --------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= S_IDLE;
      r_cnt   <= '0;
    end else if (i_flush) begin
      r_state <= S_IDLE;
    end else begin
      case (r_state)
        S_IDLE: begin
          if (i_start) begin
            r_state <= (w_div_zero || w_ovf) ? S_DONE : S_CALC;
            r_cnt   <= CNT_W'(XLEN - 1);
          end
        end
        S_CALC: begin
          r_cnt <= r_cnt - 1'b1;
          if (r_cnt == '0) begin
            r_state <= S_FIX;
          end
        end
        S_FIX:   r_state <= S_DONE;
        S_DONE: begin
          if (i_resp_ready) begin
            r_state <= S_IDLE;        // Multiplier owns the port otherwise
          end
        end
        default: r_state <= S_IDLE;
      endcase
    end
  end

  // --------------------
  // Datapath
  // --------------------
  always_ff @(posedge i_clk) begin
    case (r_state)
      S_IDLE: begin
        if (i_start) begin
          r_tag    <= i_tag;
          r_is_rem <= w_is_rem;
          r_q_neg  <= w_signed && (i_rs1[XLEN-1] ^ i_rs2[XLEN-1]);
          r_r_neg  <= w_signed && i_rs1[XLEN-1];    // Remainder follows dividend
          r_quo    <= w_abs1;
          r_dvs    <= w_abs2;
          r_rem    <= '0;
          if (w_div_zero) begin
            r_res <= w_is_rem ? i_rs1 : '1;
          end else if (w_ovf) begin
            r_res <= w_is_rem ? '0 : i_rs1;
          end
        end
      end
      S_CALC: begin
        if (!w_diff[XLEN+1]) begin
          r_rem <= w_diff[XLEN-1:0];
          r_quo <= {r_quo[XLEN-2:0], 1'b1};
        end else begin
          r_rem <= w_shift[XLEN-1:0];           // Restore
          r_quo <= {r_quo[XLEN-2:0], 1'b0};
        end
      end
      S_FIX: begin
        if (r_is_rem) begin
          r_res <= r_r_neg ? -r_rem : r_rem;
        end else begin
          r_res <= r_q_neg ? -r_quo : r_quo;
        end
      end
      default: begin
      end
    endcase
  end

  assign o_idle  = (r_state == S_IDLE);
  assign o_valid = (r_state == S_DONE);
  assign o_tag   = r_tag;
  assign o_res   = r_res;

endmodule

// File: verilog/muldiv_pipe.sv
/* Integer multiply/divide execution unit for RV32M.
   Dispatches to the multiplier pipe or the divider and merges both onto one port. */
module muldiv_pipe
  import muldiv_pkg::*;
#(
  parameter int MUL_UNROLL = 8
) (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_valid,
  input  muldiv_op_t       i_op,
  input  logic [TAG_W-1:0] i_tag,
  input  logic [XLEN-1:0]  i_rs1,
  input  logic [XLEN-1:0]  i_rs2,
  input  logic             i_flush,
  output logic             o_stall,
  output logic             o_valid,
  output logic [TAG_W-1:0] o_tag,
  output logic [XLEN-1:0]  o_res
);

  logic             w_is_mul;
  logic             w_is_div;
  logic             w_accept;
  logic             w_mul_start;
  logic             w_div_start;

  logic             w_mul_valid;
  logic [TAG_W-1:0] w_mul_tag;
  logic [XLEN-1:0]  w_mul_res;

  logic             w_div_idle;
  logic             w_div_valid;
  logic [TAG_W-1:0] w_div_tag;
  logic [XLEN-1:0]  w_div_res;

  // --------------------
  // Issue
  // --------------------
  assign w_is_mul = i_op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
  assign w_is_div = i_op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};

  assign w_accept    = i_valid & w_div_idle & ~i_flush;   // Same-cycle flush drops it
  assign w_mul_start = w_accept & w_is_mul;
  assign w_div_start = w_accept & w_is_div;

  assign o_stall = ~w_div_idle;

  mul_pipe #(
    .MUL_UNROLL (MUL_UNROLL)
  ) u_mul_pipe (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_start   (w_mul_start),
    .i_op      (i_op),
    .i_tag     (i_tag),
    .i_rs1     (i_rs1),
    .i_rs2     (i_rs2),
    .i_flush   (i_flush),
    .o_valid   (w_mul_valid),
    .o_tag     (w_mul_tag),
    .o_res     (w_mul_res)
  );

  div_unit u_div_unit (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_start      (w_div_start),
    .i_op         (i_op),
    .i_tag        (i_tag),
    .i_rs1        (i_rs1),
    .i_rs2        (i_rs2),
    .i_flush      (i_flush),
    .i_resp_ready (~w_mul_valid),    // Divider waits behind a product
    .o_idle       (w_div_idle),
    .o_valid      (w_div_valid),
    .o_tag        (w_div_tag),
    .o_res        (w_div_res)
  );

  // --------------------
  // Result merge
  // --------------------
  assign o_valid = w_mul_valid | w_div_valid;
  assign o_tag   = w_mul_valid ? w_mul_tag : w_div_tag;   // Multiplier has priority
  assign o_res   = w_mul_valid ? w_mul_res : w_div_res;

endmodule

// File: sim/muldiv_checker.sv
/* Scoreboard for the multiply/divide unit, keyed by rename tag.
   Watches the DUT ports, predicts every result and counts mismatches. */
module muldiv_checker
  import muldiv_pkg::*;
#(
  parameter int MUL_UNROLL = 8
) (
  input logic             i_clk,
  input logic             i_reset_n,
  input logic             i_valid,
  input muldiv_op_t       i_op,
  input logic [TAG_W-1:0] i_tag,
  input logic [XLEN-1:0]  i_rs1,
  input logic [XLEN-1:0]  i_rs2,
  input logic             i_flush,
  input logic             i_stall,
  input logic             i_res_valid,
  input logic [TAG_W-1:0] i_res_tag,
  input logic [XLEN-1:0]  i_res
);

  localparam int MUL_STEP = (XLEN + MUL_UNROLL - 1) / MUL_UNROLL;
  localparam int NTAGS    = 1 << TAG_W;

  logic            pend      [0:NTAGS-1];
  logic            pend_mul  [0:NTAGS-1];
  logic [XLEN-1:0] exp_res   [0:NTAGS-1];
  int              issue_cyc [0:NTAGS-1];

  string test_name    = "none";
  int    cycle        = 0;
  int    n_pending    = 0;
  int    n_checked    = 0;
  int    n_value_err  = 0;
  int    n_timing_err = 0;
  int    n_proto_err  = 0;
  logic  div_pending  = 1'b0;

  // RISC-V M extension semantics, special cases included
  function automatic logic [XLEN-1:0] ref_result(input muldiv_op_t op,
                                                 input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0] ea;
    logic [2*XLEN-1:0] eb;
    logic [2*XLEN-1:0] prod;
    logic              ovf;
    logic [XLEN-1:0]   res;
    ea   = (op == OP_MULHU) ? {{XLEN{1'b0}}, a} : {{XLEN{a[XLEN-1]}}, a};
    eb   = (op == OP_MUL || op == OP_MULH) ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
    prod = ea * eb;
    ovf  = (a == {1'b1, {(XLEN - 1){1'b0}}}) && (b == '1);
    res  = '0;
    case (op)
      OP_MUL:                       res = prod[XLEN-1:0];
      OP_MULH, OP_MULHSU, OP_MULHU: res = prod[2*XLEN-1:XLEN];
      OP_DIV: begin
        if (b == '0) res = '1;
        else if (ovf) res = a;
        else res = $signed(a) / $signed(b);   // Rounds toward zero
      end
      OP_DIVU: begin
        if (b == '0) res = '1;
        else res = a / b;
      end
      OP_REM: begin
        if (b == '0) res = a;
        else if (ovf) res = '0;
        else res = $signed(a) % $signed(b);   // Sign of dividend
      end
      OP_REMU: begin
        if (b == '0) res = a;
        else res = a % b;
      end
      default: res = '0;
    endcase
    return res;
  endfunction

  task automatic start_test(input string name);
    test_name = name;
    $display("--- test %s", name);
  endtask

  task automatic clear_all();
    for (int i = 0; i < NTAGS; i++) begin
      pend[i] = 1'b0;
    end
    n_pending   = 0;
    div_pending = 1'b0;
  endtask

  task automatic check_result();
    logic [TAG_W-1:0] t;
    t = i_res_tag;
    if (!pend[t]) begin
      $display("Result with tag %0d arrived at cycle %0d but no operation with that tag is pending",
               t, cycle);
      n_proto_err++;
    end else begin
      n_checked++;
      if (i_res !== exp_res[t]) begin
        $display("[ERROR] %s tag %0d: expected %h, actual %h", test_name, t, exp_res[t], i_res);
        n_value_err++;
      end
      if (pend_mul[t] && ((cycle - issue_cyc[t]) != MUL_STEP)) begin
        $display("[ERROR] %s tag %0d latency: expected %0d, actual %0d",
                 test_name, t, MUL_STEP, cycle - issue_cyc[t]);
        n_timing_err++;
      end
      if (!pend_mul[t]) div_pending = 1'b0;
      pend[t] = 1'b0;
      n_pending--;
    end
  endtask

  task automatic record_issue();
    if (pend[i_tag]) begin
      $display("Tag %0d was issued again while still pending", i_tag);
      n_proto_err++;
    end else begin
      n_pending++;
    end
    pend[i_tag]      = 1'b1;
    pend_mul[i_tag]  = i_op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
    exp_res[i_tag]   = ref_result(i_op, i_rs1, i_rs2);
    issue_cyc[i_tag] = cycle;
    if (!pend_mul[i_tag]) div_pending = 1'b1;
  endtask

  // --------------------
  // Edge sampling
  // --------------------
  always @(posedge i_clk) begin
    cycle = cycle + 1;
    if (!i_reset_n) begin
      if (i_res_valid !== 1'b0 || i_stall !== 1'b0) begin
        $display("Result valid or stall is not low during reset at cycle %0d", cycle);
        n_proto_err++;
      end
      clear_all();
    end else begin
      if (i_stall !== div_pending) begin    // Stall tracks the divide in flight
        $display("Stall is %b at cycle %0d while divide pending is %b", i_stall, cycle,
                 div_pending);
        n_proto_err++;
      end
      if (i_res_valid === 1'b1) begin
        check_result();
      end else if (i_res_valid !== 1'b0) begin
        $display("Result valid is unknown at cycle %0d", cycle);
        n_proto_err++;
      end
      if (i_flush) begin
        clear_all();                        // Drops the same-cycle offer too
      end else if (i_valid && !i_stall) begin
        record_issue();
      end
    end
  end

endmodule

// File: sim/tb_muldiv.sv
/* Testbench for the multiply/divide unit: clock, reset and stimulus.
   The muldiv_checker instance beside the DUT does all the comparing. */
module tb_muldiv
  import muldiv_pkg::*;
#(
  parameter int MUL_UNROLL = 8
);

  localparam int              MUL_STEP = (XLEN + MUL_UNROLL - 1) / MUL_UNROLL;
  localparam int              WAIT_MAX = 200;
  localparam int              N_DIR    = 10;
  localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN - 1){1'b0}}};

  logic             i_clk;
  logic             i_reset_n;
  logic             i_valid;
  muldiv_op_t       i_op;
  logic [TAG_W-1:0] i_tag;
  logic [XLEN-1:0]  i_rs1;
  logic [XLEN-1:0]  i_rs2;
  logic             i_flush;
  logic             o_stall;
  logic             o_valid;
  logic [TAG_W-1:0] o_tag;
  logic [XLEN-1:0]  o_res;

  logic [TAG_W-1:0] next_tag;
  int               n_timeout;
  int               n_total;

  muldiv_op_t      div_ops [4]     = '{OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  logic [XLEN-1:0] dir_a   [N_DIR] = '{32'h0000_1234, MOST_NEG, MOST_NEG, 32'hffff_fff9,
                                       32'h0000_0007, 32'hffff_fff9, MOST_NEG, 32'h0000_0000,
                                       32'hffff_ffff, 32'hffff_ff9c};
  logic [XLEN-1:0] dir_b   [N_DIR] = '{32'h0000_0000, 32'h0000_0000, 32'hffff_ffff,
                                       32'h0000_0002, 32'hffff_fffe, 32'hffff_fffe,
                                       32'h0000_0001, 32'h0000_0005, 32'hffff_ffff,
                                       32'h0000_0007};

  always #2 i_clk = ~i_clk;

  muldiv_pipe #(
    .MUL_UNROLL (MUL_UNROLL)
  ) UUT (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (i_valid),
    .i_op      (i_op),
    .i_tag     (i_tag),
    .i_rs1     (i_rs1),
    .i_rs2     (i_rs2),
    .i_flush   (i_flush),
    .o_stall   (o_stall),
    .o_valid   (o_valid),
    .o_tag     (o_tag),
    .o_res     (o_res)
  );

  muldiv_checker #(
    .MUL_UNROLL (MUL_UNROLL)
  ) u_checker (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_valid     (i_valid),
    .i_op        (i_op),
    .i_tag       (i_tag),
    .i_rs1       (i_rs1),
    .i_rs2       (i_rs2),
    .i_flush     (i_flush),
    .i_stall     (o_stall),
    .i_res_valid (o_valid),
    .i_res_tag   (o_tag),
    .i_res       (o_res)
  );

  function automatic muldiv_op_t pick_mul_op();
    case ($urandom_range(3, 0))
      0:       return OP_MUL;
      1:       return OP_MULH;
      2:       return OP_MULHSU;
      default: return OP_MULHU;
    endcase
  endfunction

  function automatic muldiv_op_t pick_div_op();
    case ($urandom_range(3, 0))
      0:       return OP_DIV;
      1:       return OP_DIVU;
      2:       return OP_REM;
      default: return OP_REMU;
    endcase
  endfunction

  // --------------------
  // Drive helpers
  // --------------------
  task automatic offer(input muldiv_op_t op, input logic [XLEN-1:0] a,
                       input logic [XLEN-1:0] b);
    @(posedge i_clk);
    i_valid <= 1'b1;
    i_op    <= op;
    i_tag   <= next_tag;
    i_rs1   <= a;
    i_rs2   <= b;
    next_tag = next_tag + 1'b1;
  endtask

  task automatic go_idle();
    @(posedge i_clk);
    i_valid <= 1'b0;
    i_flush <= 1'b0;
  endtask

  task automatic wait_not_stalled();
    int n;
    for (n = 0; n < WAIT_MAX; n++) begin
      @(negedge i_clk);
      if (!o_stall) break;
    end
    if (n == WAIT_MAX) begin
      $display("Timeout: stall did not drop within %0d cycles", WAIT_MAX);
      n_timeout++;
    end
  endtask

  task automatic wait_drain();
    int n;
    for (n = 0; n < WAIT_MAX; n++) begin
      @(negedge i_clk);
      if (u_checker.n_pending == 0) break;
    end
    if (n == WAIT_MAX) begin
      $display("Timeout: %0d results still outstanding after %0d cycles",
               u_checker.n_pending, WAIT_MAX);
      n_timeout++;
    end
  endtask

  // Divider holds off further issue until its result is out
  task automatic run_div(input muldiv_op_t op, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b);
    offer(op, a, b);
    go_idle();
    wait_not_stalled();
  endtask

  initial begin
    void'($urandom(32'h31af));
    i_clk     = 1'b0;
    i_reset_n <= 1'b0;
    i_valid   <= 1'b0;
    i_op      <= OP_NONE;
    i_tag     <= '0;
    i_rs1     <= '0;
    i_rs2     <= '0;
    i_flush   <= 1'b0;
    next_tag  = '0;
    n_timeout = 0;

    u_checker.start_test("reset");
    repeat (4) @(posedge i_clk);
    i_reset_n <= 1'b1;
    repeat (3) @(posedge i_clk);            // Outputs must stay quiet

    u_checker.start_test("mul_random");
    for (int i = 0; i < 200; i++) begin
      offer(pick_mul_op(), $urandom, $urandom);
    end
    go_idle();
    wait_drain();

    u_checker.start_test("div_random");
    for (int i = 0; i < 40; i++) begin
      run_div(pick_div_op(), $urandom, $urandom >> $urandom_range(31, 0));
    end
    wait_drain();

    u_checker.start_test("div_directed");
    for (int k = 0; k < 4; k++) begin
      for (int j = 0; j < N_DIR; j++) begin
        run_div(div_ops[k], dir_a[j], dir_b[j]);
      end
    end
    wait_drain();

    // Products still in the pipe collide with a one-cycle divide
    u_checker.start_test("overlap");
    for (int k = 1; k <= MUL_STEP + 1; k++) begin
      for (int i = 0; i < k; i++) begin
        offer(pick_mul_op(), $urandom, $urandom);
      end
      if (k % 2 == 1) begin
        run_div(pick_div_op(), $urandom, '0);
      end else begin
        run_div(OP_DIV, MOST_NEG, '1);
      end
      wait_drain();
    end

    u_checker.start_test("flush");
    offer(OP_DIVU, $urandom, 32'h0000_0003);
    go_idle();
    repeat (5) @(posedge i_clk);            // Divider mid-calculation
    @(posedge i_clk);
    i_flush <= 1'b1;
    go_idle();
    for (int i = 0; i < MUL_STEP - 1; i++) begin
      offer(pick_mul_op(), $urandom, $urandom);
    end
    offer(OP_MUL, $urandom, $urandom);
    i_flush <= 1'b1;                        // Same-cycle offer is dropped
    go_idle();
    repeat (2 * MUL_STEP) @(posedge i_clk);

    u_checker.start_test("after_flush");
    for (int i = 0; i < 16; i++) begin
      offer(pick_mul_op(), $urandom, $urandom);
    end
    go_idle();
    run_div(OP_REM, $urandom, $urandom >> 20);
    wait_drain();

    repeat (4) @(posedge i_clk);
    n_total = u_checker.n_value_err + u_checker.n_timing_err + u_checker.n_proto_err + n_timeout;
    $display("Checked %0d results: %0d value, %0d timing, %0d protocol errors, %0d timeouts",
             u_checker.n_checked, u_checker.n_value_err, u_checker.n_timing_err,
             u_checker.n_proto_err, n_timeout);
    if (n_total == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: muldiv.f
verilog/muldiv_pkg.sv
verilog/mul_pipe.sv
verilog/div_unit.sv
verilog/muldiv_pipe.sv
sim/muldiv_checker.sv
sim/tb_muldiv.sv

// File: Makefile
# Verilator build, run and lint of the RV32M multiply/divide unit

VERILATOR  ?= verilator
TOP        ?= tb_muldiv
RTL_TOP    ?= muldiv_pipe
FILELIST   ?= muldiv.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
MUL_UNROLL ?= 8
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GMUL_UNROLL=$(MUL_UNROLL) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) && echo "PASS" || \
		(echo "FAIL: see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
